// ==== logic/mem_pkg.sv ====
// data, address, index and mask widths, their typedefs and the RAM geometry
package mem_pkg;

    // machine word and byte address
    localparam int XLEN = 64;
    localparam int ADDR_W = 64;

    // doubleword RAM geometry
    localparam int INDEX_W = 8;
    localparam int OFF_W = 3;
    localparam int MASK_W = 8;
    localparam int RAM_DEPTH = 256;
    localparam int WINDOW_BYTES = 2048;

    // window base out of reset
    localparam logic [ADDR_W-1:0] RESET_BASE = 64'h8000_0000;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // doubleword slot inside the window
    typedef logic [INDEX_W-1:0] ram_index_t;

    // one enable per byte lane
    typedef logic [MASK_W-1:0] byte_mask_t;

    // byte position inside a doubleword
    typedef logic [OFF_W-1:0] byte_off_t;

endpackage

// ==== logic/lsu_pkg.sv ====
// access width enum, fault cause encoding and configuration register map
package lsu_pkg;

    // access size, shared by loads and stores
    typedef enum logic [1:0] {
        WIDTH_B = 2'b00,
        WIDTH_H = 2'b01,
        WIDTH_W = 2'b10,
        WIDTH_D = 2'b11
    } width_op_t;

    // fault cause bits
    typedef logic [1:0] cause_t;
    localparam int CAUSE_MISALIGN_BIT = 0;
    localparam int CAUSE_RANGE_BIT = 1;

    // configuration register addresses
    localparam logic [1:0] CFG_BASE = 2'd0;
    localparam logic [1:0] CFG_FAULT_ADDR = 2'd1;
    localparam logic [1:0] CFG_FAULT_COUNT = 2'd2;
    localparam logic [1:0] CFG_FAULT_CAUSE = 2'd3;

endpackage

// ==== logic/access_check.sv ====
// access_check: window translation, alignment and range checks, gated RAM enables
`timescale 1ns/10ps

module access_check
    import mem_pkg::*;
    import lsu_pkg::*;
(
    input  addr_t      raddr,
    input  addr_t      waddr,
    input  logic       ren,
    input  logic       wen,
    input  width_op_t  width,
    input  addr_t      base,
    output logic       ram_ren,
    output logic       ram_wen,
    output ram_index_t rindex,
    output ram_index_t windex,
    output byte_off_t  roff,
    output byte_off_t  woff,
    output logic       rd_fault,
    output logic       wr_fault,
    output cause_t     rd_cause,
    output cause_t     wr_cause
);

    addr_t r_rel;
    addr_t w_rel;

    // true when the address is not a multiple of the access size
    function automatic logic is_misaligned(input addr_t addr, input width_op_t w);
        case (w)
            WIDTH_B: is_misaligned = 1'b0;
            WIDTH_H: is_misaligned = addr[0];
            WIDTH_W: is_misaligned = |addr[1:0];
            default: is_misaligned = |addr[2:0];
        endcase
    endfunction

    // offset into the window, unsigned so addresses below base wrap high
    assign r_rel = raddr - base;
    assign w_rel = waddr - base;

    assign rindex = r_rel[OFF_W +: INDEX_W];
    assign windex = w_rel[OFF_W +: INDEX_W];
    assign roff = r_rel[OFF_W-1:0];
    assign woff = w_rel[OFF_W-1:0];

    assign rd_cause[CAUSE_MISALIGN_BIT] = is_misaligned(raddr, width);
    assign rd_cause[CAUSE_RANGE_BIT] = r_rel >= addr_t'(WINDOW_BYTES);
    assign wr_cause[CAUSE_MISALIGN_BIT] = is_misaligned(waddr, width);
    assign wr_cause[CAUSE_RANGE_BIT] = w_rel >= addr_t'(WINDOW_BYTES);

    // refused accesses never reach the RAM
    assign rd_fault = ren & (|rd_cause);
    assign wr_fault = wen & (|wr_cause);
    assign ram_ren = ren & ~(|rd_cause);
    assign ram_wen = wen & ~(|wr_cause);

endmodule

// ==== logic/store_align.sv ====
// store_align: byte mask and lane placement of store data
`timescale 1ns/10ps

module store_align
    import mem_pkg::*;
    import lsu_pkg::*;
(
    input  xlen_t      wdata,
    input  width_op_t  width,
    input  byte_off_t  woff,
    output byte_mask_t wmask,
    output xlen_t      wline
);

    byte_mask_t size_mask;

    // low-aligned mask by access size
    always_comb begin
        case (width)
            WIDTH_B: size_mask = 8'h01;
            WIDTH_H: size_mask = 8'h03;
            WIDTH_W: size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // move the mask to the addressed lanes
    assign wmask = size_mask << woff;

    // low bytes of wdata land on the masked lanes
    // bits shifted past the mask are never written
    assign wline = wdata << {woff, 3'b000};

endmodule

// ==== logic/load_align.sv ====
// load_align: registered load offset and width, lane select, zero extension, valid pulse
`timescale 1ns/10ps

module load_align
    import mem_pkg::*;
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ram_ren,
    input  byte_off_t roff,
    input  width_op_t width,
    input  xlen_t     rline,
    output xlen_t     rdata,
    output logic      rvalid
);

    logic      valid_q;
    byte_off_t off_q;
    width_op_t width_q;
    xlen_t     lane;

    // valid flag follows each accepted load by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ram_ren;
        end
    end

    // offset and width travel alongside the RAM read
    always_ff @(posedge clk) begin
        if (ram_ren) begin
            off_q <= roff;
            width_q <= width;
        end
    end

    // addressed byte moved down to bit 0
    assign lane = rline >> {off_q, 3'b000};

    always_comb begin
        case (width_q)
            WIDTH_B: rdata = {56'd0, lane[7:0]};
            WIDTH_H: rdata = {48'd0, lane[15:0]};
            WIDTH_W: rdata = {32'd0, lane[31:0]};
            default: rdata = lane;
        endcase
    end

    assign rvalid = valid_q;

endmodule

// ==== logic/data_ram.sv ====
// data_ram: 256 x 64-bit RAM, byte-masked write, registered read-before-write
`timescale 1ns/10ps

module data_ram
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       ren,
    input  logic       wen,
    input  ram_index_t rindex,
    input  ram_index_t windex,
    input  byte_mask_t wmask,
    input  xlen_t      wline,
    output xlen_t      rline
);

    xlen_t mem [RAM_DEPTH];

    // only the masked lanes change
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (wmask[i]) begin
                    mem[windex][8*i +: 8] <= wline[8*i +: 8];
                end
            end
        end
    end

    // same-edge write to this slot is not visible yet
    always_ff @(posedge clk) begin
        if (ren) begin
            rline <= mem[rindex];
        end
    end

endmodule

// ==== logic/mem_csr.sv ====
// mem_csr: window base, fault address and cause capture, saturating fault counter
`timescale 1ns/10ps

module mem_csr
    import mem_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_wen,
    input  logic [1:0] cfg_addr,
    input  xlen_t      cfg_wdata,
    input  logic       rd_fault,
    input  logic       wr_fault,
    input  cause_t     rd_cause,
    input  cause_t     wr_cause,
    input  addr_t      raddr,
    input  addr_t      waddr,
    output xlen_t      cfg_rdata,
    output addr_t      base
);

    addr_t           base_q;
    addr_t           fault_addr_q;
    cause_t          fault_cause_q;
    xlen_t           fault_count_q;
    logic [1:0]      fault_num;
    logic [XLEN:0]   count_sum;

    // zero, one or two faults per cycle
    assign fault_num = {1'b0, rd_fault} + {1'b0, wr_fault};
    assign count_sum = {1'b0, fault_count_q} + (XLEN+1)'(fault_num);

    always_ff @(posedge clk) begin
        if (rst) begin
            base_q <= RESET_BASE;
            fault_addr_q <= '0;
            fault_cause_q <= '0;
            fault_count_q <= '0;
        end else begin
            if (cfg_wen && cfg_addr == CFG_BASE) begin
                base_q <= cfg_wdata;
            end
            // load fault takes priority over store fault
            if (rd_fault) begin
                fault_addr_q <= raddr;
                fault_cause_q <= rd_cause;
            end else if (wr_fault) begin
                fault_addr_q <= waddr;
                fault_cause_q <= wr_cause;
            end
            // clear beats any fault in the same cycle
            if (cfg_wen && cfg_addr == CFG_FAULT_COUNT) begin
                fault_count_q <= '0;
            end else if (count_sum[XLEN]) begin
                fault_count_q <= '1;
            end else begin
                fault_count_q <= count_sum[XLEN-1:0];
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_BASE:        cfg_rdata = base_q;
            CFG_FAULT_ADDR:  cfg_rdata = fault_addr_q;
            CFG_FAULT_COUNT: cfg_rdata = fault_count_q;
            default:         cfg_rdata = xlen_t'(fault_cause_q);
        endcase
    end

    assign base = base_q;

endmodule

// ==== logic/data_mem_top.sv ====
// data_mem_top: access checks, store and load alignment, RAM and configuration block
`timescale 1ns/10ps

module data_mem_top
    import mem_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      raddr,
    input  addr_t      waddr,
    input  logic       ren,
    input  logic       wen,
    input  width_op_t  width,
    input  xlen_t      wdata,
    input  logic       cfg_wen,
    input  logic [1:0] cfg_addr,
    input  xlen_t      cfg_wdata,
    output xlen_t      rdata,
    output logic       rvalid,
    output xlen_t      cfg_rdata
);

    addr_t      base;
    logic       ram_ren;
    logic       ram_wen;
    ram_index_t rindex;
    ram_index_t windex;
    byte_off_t  roff;
    byte_off_t  woff;
    logic       rd_fault;
    logic       wr_fault;
    cause_t     rd_cause;
    cause_t     wr_cause;
    byte_mask_t wmask;
    xlen_t      wline;
    xlen_t      rline;

    access_check u_access_check (
        .raddr(raddr), .waddr(waddr), .ren(ren), .wen(wen), .width(width),
        .base(base), .ram_ren(ram_ren), .ram_wen(ram_wen),
        .rindex(rindex), .windex(windex), .roff(roff), .woff(woff),
        .rd_fault(rd_fault), .wr_fault(wr_fault),
        .rd_cause(rd_cause), .wr_cause(wr_cause)
    );

    store_align u_store_align (
        .wdata(wdata), .width(width), .woff(woff), .wmask(wmask), .wline(wline)
    );

    data_ram u_data_ram (
        .clk(clk), .ren(ram_ren), .wen(ram_wen), .rindex(rindex), .windex(windex),
        .wmask(wmask), .wline(wline), .rline(rline)
    );

    load_align u_load_align (
        .clk(clk), .rst(rst), .ram_ren(ram_ren), .roff(roff), .width(width),
        .rline(rline), .rdata(rdata), .rvalid(rvalid)
    );

    mem_csr u_mem_csr (
        .clk(clk), .rst(rst), .cfg_wen(cfg_wen), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .rd_fault(rd_fault), .wr_fault(wr_fault),
        .rd_cause(rd_cause), .wr_cause(wr_cause), .raddr(raddr), .waddr(waddr),
        .cfg_rdata(cfg_rdata), .base(base)
    );

endmodule

// ==== tests/data_mem_checker.sv ====
// bound assertions on rvalid timing, rvalid after reset and RAM write masks
`timescale 1ns/10ps

module data_mem_checker
    import mem_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       rvalid,
    input logic       ram_ren,
    input logic       ram_wen,
    input byte_mask_t wmask
);

    // two results in a row need two accepted loads in a row
    a_rvalid_pair: assert property (@(posedge clk) disable iff (rst)
        (rvalid && $past(rvalid)) |-> ($past(ram_ren, 1) && $past(ram_ren, 2)))
        else $error("rvalid high twice without two accepted loads");

    a_reset_idle: assert property (@(posedge clk) rst |=> !rvalid)
        else $error("rvalid high in the cycle after reset");

    a_write_mask: assert property (@(posedge clk) disable iff (rst) ram_wen |-> (wmask != '0))
        else $error("RAM write with an empty byte mask");

endmodule

bind data_mem_top data_mem_checker u_checker (
    .clk(clk), .rst(rst), .rvalid(rvalid), .ram_ren(ram_ren), .ram_wen(ram_wen),
    .wmask(wmask)
);

// ==== tests/data_mem_tb.sv ====
// data memory testbench with clock, reset, byte model of the window, directed tests, timeout and summary
`timescale 1ns/10ps

module data_mem_tb
    import mem_pkg::*;
    import lsu_pkg::*;
();

    // the directed tests need a few hundred cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam xlen_t EXP_MISALIGN = 64'd1;
    localparam xlen_t EXP_RANGE = 64'd2;

    logic       clk, rst, ren, wen, cfg_wen, rvalid;
    addr_t      raddr, waddr;
    width_op_t  width;
    xlen_t      wdata, cfg_wdata, rdata, cfg_rdata;
    logic [1:0] cfg_addr;

    // expected window contents by offset from the base
    logic [7:0] model [WINDOW_BYTES];
    addr_t      cur_base;
    xlen_t      exp_count;
    int         errors = 0;
    int         test_errors = 0;
    int         tests = 0;
    int         cycles;

    // loads waiting to be issued by run_loads
    addr_t      ld_addr [$];
    width_op_t  ld_width [$];
    xlen_t      ld_exp [$];
    bit         ld_ok [$];

    data_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // zero-extended little-endian bytes of the model
    function automatic xlen_t model_load(input int off, input width_op_t w);
        xlen_t val;
        val = '0;
        for (int i = 0; i < (1 << w); i++) begin
            val[8*i +: 8] = model[off + i];
        end
        return val;
    endfunction

    function automatic void model_store(input int off, input width_op_t w, input xlen_t data);
        for (int i = 0; i < (1 << w); i++) begin
            model[off + i] = data[8*i +: 8];
        end
    endfunction

    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: finished, %0d errors", name, test_errors);
        tests++;
        test_errors = 0;
    endtask

    // one cycle of load and store enables on the shared width
    task automatic access(input logic r, input addr_t ra, input logic w, input addr_t wa,
                          input width_op_t wd, input xlen_t d);
        @(posedge clk);
        ren <= r;
        raddr <= ra;
        wen <= w;
        waddr <= wa;
        width <= wd;
        wdata <= d;
        @(posedge clk);
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic store_and_model(input int off, input width_op_t w, input xlen_t data);
        access(1'b0, '0, 1'b1, cur_base + off, w, data);
        model_store(off, w, data);
    endtask

    task automatic cfg_write(input logic [1:0] addr, input xlen_t data);
        @(posedge clk);
        cfg_wen <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wen <= 1'b0;
    endtask

    // cfg_rdata is combinational and is sampled one edge after the address is set
    task automatic cfg_expect(input string name, input logic [1:0] addr, input xlen_t exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(posedge clk);
        check_value(name, exp, cfg_rdata);
    endtask

    // expected value is taken from the model when the load is queued
    task automatic queue_load(input addr_t addr, input width_op_t w, input bit ok);
        ld_addr.push_back(addr);
        ld_width.push_back(w);
        ld_exp.push_back(ok ? model_load(int'(addr - cur_base), w) : '0);
        ld_ok.push_back(ok);
    endtask

    // loads go out back to back and each result is due two edges after it is driven
    task automatic run_loads(input string name);
        int n;
        bit due;
        n = ld_addr.size();
        for (int i = 0; i < n + 3; i++) begin
            @(posedge clk);
            due = (i >= 2 && i < n + 2) ? ld_ok[i-2] : 1'b0;
            check_value({name, " rvalid"}, xlen_t'(due), xlen_t'(rvalid));
            if (due) begin
                check_value(name, ld_exp[i-2], rdata);
            end
            ren <= (i < n);
            if (i < n) begin
                raddr <= ld_addr[i];
                width <= ld_width[i];
            end
        end
        ld_addr.delete();
        ld_width.delete();
        ld_exp.delete();
        ld_ok.delete();
    endtask

    task automatic test_reset();
        check_value("reset rvalid", '0, xlen_t'(rvalid));
        cfg_expect("reset base", CFG_BASE, RESET_BASE);
        cfg_expect("reset fault count", CFG_FAULT_COUNT, '0);
        cfg_expect("reset fault cause", CFG_FAULT_CAUSE, '0);
        cfg_expect("reset fault addr", CFG_FAULT_ADDR, '0);
        report_test("reset");
    endtask

    // every width at every aligned offset of the first and last doubleword
    task automatic test_widths();
        for (int dw = 0; dw <= 2040; dw += 2040) begin
            store_and_model(dw, WIDTH_D, {$urandom, $urandom});
            for (int w = 0; w < 4; w++) begin
                for (int o = 0; o < 8; o += 1 << w) begin
                    queue_load(cur_base + dw + o, width_op_t'(w), 1'b1);
                end
            end
        end
        run_loads("widths");
        report_test("widths");
    endtask

    task automatic test_masked();
        xlen_t new_line;
        store_and_model(64, WIDTH_D, 64'h0123_4567_89ab_cdef);
        // random upper bytes of wdata must stay outside the mask
        store_and_model(65, WIDTH_B, {$urandom, $urandom});
        store_and_model(66, WIDTH_H, {$urandom, $urandom});
        store_and_model(68, WIDTH_W, {$urandom, $urandom});
        store_and_model(72, WIDTH_D, {$urandom, $urandom});
        queue_load(cur_base + 64, WIDTH_D, 1'b1);
        queue_load(cur_base + 72, WIDTH_D, 1'b1);
        queue_load(cur_base + 2040, WIDTH_D, 1'b1);
        run_loads("masked back to back");
        // load and store of one doubleword at the same edge
        new_line = {$urandom, $urandom};
        access(1'b1, cur_base + 72, 1'b1, cur_base + 72, WIDTH_D, new_line);
        @(posedge clk);
        check_value("masked same edge rvalid", 64'd1, xlen_t'(rvalid));
        check_value("masked same edge", model_load(72, WIDTH_D), rdata);
        model_store(72, WIDTH_D, new_line);
        queue_load(cur_base + 72, WIDTH_D, 1'b1);
        run_loads("masked after store");
        report_test("masked");
    endtask

    task automatic test_misaligned();
        queue_load(cur_base + 65, WIDTH_H, 1'b0);
        run_loads("misaligned load");
        exp_count++;
        cfg_expect("misaligned load count", CFG_FAULT_COUNT, exp_count);
        cfg_expect("misaligned load addr", CFG_FAULT_ADDR, cur_base + 65);
        cfg_expect("misaligned load cause", CFG_FAULT_CAUSE, EXP_MISALIGN);
        access(1'b0, '0, 1'b1, cur_base + 66, WIDTH_W, {$urandom, $urandom});
        exp_count++;
        cfg_expect("misaligned store count", CFG_FAULT_COUNT, exp_count);
        cfg_expect("misaligned store addr", CFG_FAULT_ADDR, cur_base + 66);
        cfg_expect("misaligned store cause", CFG_FAULT_CAUSE, EXP_MISALIGN);
        // refused store leaves the doubleword as it was
        queue_load(cur_base + 64, WIDTH_D, 1'b1);
        run_loads("misaligned store untouched");
        report_test("misaligned");
    endtask

    task automatic test_base();
        addr_t new_base;
        // not 2 KiB aligned, so raw address bits differ from the window index
        new_base = 64'h4000_1100;
        cfg_write(CFG_BASE, new_base);
        cur_base = new_base;
        cfg_expect("base readback", CFG_BASE, new_base);
        queue_load(new_base - 8, WIDTH_D, 1'b0);
        run_loads("base below window");
        access(1'b0, '0, 1'b1, new_base + 2048, WIDTH_D, {$urandom, $urandom});
        exp_count += 2;
        cfg_expect("base range count", CFG_FAULT_COUNT, exp_count);
        cfg_expect("base range addr", CFG_FAULT_ADDR, new_base + 2048);
        cfg_expect("base range cause", CFG_FAULT_CAUSE, EXP_RANGE);
        store_and_model(0, WIDTH_D, {$urandom, $urandom});
        queue_load(new_base, WIDTH_D, 1'b1);
        // data stored under the old base stays at its window offset
        queue_load(new_base + 64, WIDTH_D, 1'b1);
        run_loads("base store readback");
        // misaligned load outside the window together with a store below it
        access(1'b1, new_base + 4097, 1'b1, new_base - 16, WIDTH_D, {$urandom, $urandom});
        exp_count += 2;
        cfg_expect("dual fault count", CFG_FAULT_COUNT, exp_count);
        cfg_expect("dual fault addr", CFG_FAULT_ADDR, new_base + 4097);
        cfg_expect("dual fault cause", CFG_FAULT_CAUSE, EXP_MISALIGN | EXP_RANGE);
        cfg_write(CFG_FAULT_COUNT, {$urandom, $urandom});
        cfg_expect("fault count clear", CFG_FAULT_COUNT, '0);
        report_test("base");
    endtask

    initial begin
        void'($urandom(32'h830c_2c84));
        rst = 1'b1;
        ren = 1'b0;
        wen = 1'b0;
        raddr = '0;
        waddr = '0;
        width = WIDTH_D;
        wdata = '0;
        cfg_wen = 1'b0;
        cfg_addr = CFG_BASE;
        cfg_wdata = '0;
        cur_base = RESET_BASE;
        exp_count = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_widths();
        test_masked();
        test_misaligned();
        test_base();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/mem_pkg.sv
logic/lsu_pkg.sv
logic/access_check.sv
logic/store_align.sv
logic/load_align.sv
logic/data_ram.sv
logic/mem_csr.sv
logic/data_mem_top.sv
tests/data_mem_checker.sv
tests/data_mem_tb.sv
